//--- common/isaPkg.sv
//////////////////////////////////////////////////////////////////////
// ISA definitions for the 16-bit pipelined processor: widths,
// instruction field positions and opcode values
//////////////////////////////////////////////////////////////////////
`default_nettype none

package isaPkg;

    localparam int wordWidth = 16;  // data and instruction width
    localparam int numRegs = 8;
    localparam int regBits = $clog2(numRegs);
    localparam int opcodeBits = 3;
    localparam int immBits = 9;

    // word layout is  III M XXX DDDDDDDDD  or  III M XXX 000000 YYY
    localparam int opcodeLsb = wordWidth - opcodeBits;  // bits 15..13
    localparam int immFlagBit = opcodeLsb - 1;  // M
    localparam int rxLsb = immFlagBit - regBits;  // bits 11..9
    localparam int ryLsb = 0;  // bits 2..0

    localparam logic [opcodeBits-1:0] opMv = 3'b000;
    localparam logic [opcodeBits-1:0] opMvtB = 3'b001;  // mvt when M set, bnz otherwise
    localparam logic [opcodeBits-1:0] opAdd = 3'b010;
    localparam logic [opcodeBits-1:0] opSub = 3'b011;
    localparam logic [opcodeBits-1:0] opLd = 3'b100;
    localparam logic [opcodeBits-1:0] opSt = 3'b101;
    localparam logic [opcodeBits-1:0] opAnd = 3'b110;
    localparam logic [opcodeBits-1:0] opOther = 3'b111;  // runs as a nop

endpackage

`default_nettype wire

//--- common/pipePkg.sv
//////////////////////////////////////////////////////////////////////
// Pipeline-internal encodings: ALU operation and result source
//////////////////////////////////////////////////////////////////////
`default_nettype none

package pipePkg;

    typedef enum logic [2:0] {
        aluPassB,
        aluAdd,
        aluSub,
        aluAnd,
        aluUpperByte  // low byte of B moved to the upper byte
    } aluOpT;

    // where the value written back to rX comes from
    typedef enum logic [1:0] {
        srcAlu,
        srcMemory,
        srcNone  // no register write
    } resultSrcT;

endpackage

`default_nettype wire

//--- verilog/fetchUnit.sv
//////////////////////////////////////////////////////////////////////
// Fetch stage: program counter, instruction address and fetch register
//////////////////////////////////////////////////////////////////////
`default_nettype none

module fetchUnit (
    input  wire                           Clock,
    input  wire                           Reset,
    input  wire                           hold,
    input  wire                           loadUseStall,
    input  wire                           branchTaken,
    input  wire [isaPkg::wordWidth-1:0]   branchTarget,
    input  wire [isaPkg::wordWidth-1:0]   InstrIn,
    output logic [isaPkg::wordWidth-1:0]  InstrAddr,
    output logic [isaPkg::wordWidth-1:0]  instrWord,
    output logic [isaPkg::wordWidth-1:0]  instrPc,
    output logic                          fetchValid
);
    import isaPkg::*;

    logic [wordWidth-1:0] heldWord;  // word in decode kept while the ROM moves on
    logic heldValid;
    logic advance;

    assign advance = !hold && !loadUseStall;
    assign instrWord = heldValid ? heldWord : InstrIn;

    // InstrAddr is the PC; the ROM answers one cycle later
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            InstrAddr <= '0;
            instrPc <= '0;
            fetchValid <= 1'b0;
            heldValid <= 1'b0;
        end else if (branchTaken && !hold) begin
            InstrAddr <= branchTarget;
            fetchValid <= 1'b0;  // squash the word already on its way
            heldValid <= 1'b0;
        end else if (advance) begin
            InstrAddr <= InstrAddr + 1'b1;
            instrPc <= InstrAddr;
            fetchValid <= 1'b1;
            heldValid <= 1'b0;
        end else begin
            heldValid <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (!heldValid)
            heldWord <= InstrIn;  // frozen from the first stalled cycle on
    end

endmodule

`default_nettype wire

//--- decode/instrDecoder.sv
//////////////////////////////////////////////////////////////////////
// Decode stage: instruction fields, control, operand read and
// load-use hazard detection
//////////////////////////////////////////////////////////////////////
`default_nettype none

module instrDecoder (
    input  wire [isaPkg::wordWidth-1:0]   instrWord,
    input  wire [isaPkg::wordWidth-1:0]   instrPc,
    input  wire                           fetchValid,
    input  wire                           exMemRead,
    input  wire [isaPkg::regBits-1:0]     exDestReg,
    input  wire [isaPkg::wordWidth-1:0]   readDataA,
    input  wire [isaPkg::wordWidth-1:0]   readDataB,
    output logic [isaPkg::regBits-1:0]    readRegA,
    output logic [isaPkg::regBits-1:0]    readRegB,
    output pipePkg::aluOpT                aluOp,
    output pipePkg::resultSrcT            resultSrc,
    output logic                          memRead,
    output logic                          memWrite,
    output logic                          writeEnable,
    output logic [isaPkg::regBits-1:0]    destReg,
    output logic [isaPkg::regBits-1:0]    srcRegA,
    output logic [isaPkg::regBits-1:0]    srcRegB,
    output logic [isaPkg::wordWidth-1:0]  operandA,
    output logic [isaPkg::wordWidth-1:0]  operandB,
    output logic                          useImm,
    output logic [isaPkg::wordWidth-1:0]  imm,
    output logic                          isBranch,
    output logic [isaPkg::wordWidth-1:0]  decPc,
    output logic                          loadUseStall
);
    import isaPkg::*;
    import pipePkg::*;

    logic [opcodeBits-1:0] opcode;
    logic immFlag;
    logic [immBits-1:0] immField;
    logic usesA;  // rX is read as a source
    logic usesB;  // rY is read as a source

    assign opcode = instrWord[opcodeLsb +: opcodeBits];
    assign immFlag = instrWord[immFlagBit];
    assign immField = instrWord[immBits-1:0];
    assign srcRegA = instrWord[rxLsb +: regBits];
    assign srcRegB = instrWord[ryLsb +: regBits];
    assign destReg = srcRegA;
    assign readRegA = srcRegA;
    assign readRegB = srcRegB;
    assign operandA = readDataA;
    assign operandB = readDataB;
    assign decPc = instrPc;

    always_comb begin
        aluOp = aluPassB;
        resultSrc = fetchValid ? srcAlu : srcNone;
        memRead = 1'b0;
        memWrite = 1'b0;
        isBranch = 1'b0;
        useImm = immFlag;
        usesA = 1'b0;
        usesB = !immFlag;
        imm = {{(wordWidth-immBits){1'b0}}, immField};
        case (opcode)
            opMv: aluOp = aluPassB;
            opMvtB: begin
                if (immFlag) begin
                    aluOp = aluUpperByte;
                end else begin
                    // bnz: offset is signed, target built in execute
                    imm = {{(wordWidth-immBits){immField[immBits-1]}}, immField};
                    resultSrc = srcNone;
                    isBranch = fetchValid;
                    usesA = 1'b1;
                    usesB = 1'b0;
                end
            end
            opAdd: begin
                aluOp = aluAdd;
                usesA = 1'b1;
            end
            opSub: begin
                aluOp = aluSub;
                usesA = 1'b1;
            end
            opAnd: begin
                aluOp = aluAnd;
                usesA = 1'b1;
            end
            opLd: begin
                resultSrc = fetchValid ? srcMemory : srcNone;
                memRead = fetchValid;
                useImm = 1'b0;  // address always comes from rY
                usesB = 1'b1;
            end
            opSt: begin
                resultSrc = srcNone;
                memWrite = fetchValid;
                useImm = 1'b0;
                usesA = 1'b1;
                usesB = 1'b1;
            end
            opOther: begin
                resultSrc = srcNone;
                usesB = 1'b0;
            end
        endcase
    end

    assign writeEnable = resultSrc != srcNone;

    // the load now in execute delivers its data too late for this one
    assign loadUseStall = fetchValid && exMemRead &&
        ((usesA && exDestReg == srcRegA) || (usesB && exDestReg == srcRegB));

endmodule

`default_nettype wire

//--- verilog/regFile.sv
//////////////////////////////////////////////////////////////////////
// Register file: eight words, two read ports, one write port
//////////////////////////////////////////////////////////////////////
`default_nettype none

module regFile (
    input  wire                           Clock,
    input  wire                           Reset,
    input  wire [isaPkg::regBits-1:0]     readRegA,
    input  wire [isaPkg::regBits-1:0]     readRegB,
    input  wire                           wbEnable,
    input  wire [isaPkg::regBits-1:0]     wbReg,
    input  wire [isaPkg::wordWidth-1:0]   wbData,
    output logic [isaPkg::wordWidth-1:0]  readDataA,
    output logic [isaPkg::wordWidth-1:0]  readDataB
);
    import isaPkg::*;

    logic [wordWidth-1:0] regs [numRegs];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end else if (wbEnable) begin
            regs[wbReg] <= wbData;
        end
    end

    // write-through so decode sees a value written in the same cycle
    assign readDataA = (wbEnable && wbReg == readRegA) ? wbData : regs[readRegA];
    assign readDataB = (wbEnable && wbReg == readRegB) ? wbData : regs[readRegB];

endmodule

`default_nettype wire

//--- execute/aluExecute.sv
//////////////////////////////////////////////////////////////////////
// Execute stage: decode/execute register, forwarding, ALU and the
// bnz decision
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aluExecute (
    input  wire                           Clock,
    input  wire                           Reset,
    input  wire                           hold,
    input  wire                           loadUseStall,
    input  wire pipePkg::aluOpT           aluOp,
    input  wire pipePkg::resultSrcT       resultSrc,
    input  wire                           memRead,
    input  wire                           memWrite,
    input  wire                           writeEnable,
    input  wire [isaPkg::regBits-1:0]     destReg,
    input  wire [isaPkg::regBits-1:0]     srcRegA,
    input  wire [isaPkg::regBits-1:0]     srcRegB,
    input  wire [isaPkg::wordWidth-1:0]   operandA,
    input  wire [isaPkg::wordWidth-1:0]   operandB,
    input  wire                           useImm,
    input  wire [isaPkg::wordWidth-1:0]   imm,
    input  wire                           isBranch,
    input  wire [isaPkg::wordWidth-1:0]   decPc,
    input  wire [isaPkg::wordWidth-1:0]   memResult,
    input  wire                           memWriteEnable,
    input  wire [isaPkg::regBits-1:0]     memDestReg,
    input  wire                           wbEnable,
    input  wire [isaPkg::regBits-1:0]     wbReg,
    input  wire [isaPkg::wordWidth-1:0]   wbData,
    output logic                          branchTaken,
    output logic [isaPkg::wordWidth-1:0]  branchTarget,
    output logic [isaPkg::wordWidth-1:0]  exResult,
    output logic [isaPkg::wordWidth-1:0]  exStoreData,
    output logic [isaPkg::wordWidth-1:0]  exAddr,
    output logic                          exMemRead,
    output logic                          exMemWrite,
    output logic                          exWriteEnable,
    output logic [isaPkg::regBits-1:0]    exDestReg,
    output pipePkg::resultSrcT            exResultSrc
);
    import isaPkg::*;
    import pipePkg::*;

    aluOpT exAluOp;
    logic exBranch;
    logic [regBits-1:0] exSrcA;
    logic [regBits-1:0] exSrcB;
    logic [wordWidth-1:0] exOpA;
    logic [wordWidth-1:0] exOpB;
    logic exUseImm;
    logic [wordWidth-1:0] exImm;
    logic [wordWidth-1:0] exPc;
    logic [wordWidth-1:0] valueA;
    logic [wordWidth-1:0] valueB;
    logic [wordWidth-1:0] aluB;
    logic bubble;

    // newest copy of a source, memory stage first
    function automatic logic [wordWidth-1:0] forwardValue(
        input logic [regBits-1:0] src,
        input logic [wordWidth-1:0] regValue
    );
        if (memWriteEnable && memDestReg == src)
            return memResult;
        if (wbEnable && wbReg == src)
            return wbData;
        return regValue;
    endfunction

    assign bubble = loadUseStall || branchTaken;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            exMemRead <= 1'b0;
            exMemWrite <= 1'b0;
            exWriteEnable <= 1'b0;
            exBranch <= 1'b0;
            exResultSrc <= srcNone;
        end else if (!hold) begin
            exMemRead <= memRead && !bubble;
            exMemWrite <= memWrite && !bubble;
            exWriteEnable <= writeEnable && !bubble;
            exBranch <= isBranch && !bubble;
            exResultSrc <= bubble ? srcNone : resultSrc;
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold) begin
            exAluOp <= aluOp;
            exDestReg <= destReg;
            exSrcA <= srcRegA;
            exSrcB <= srcRegB;
            exOpA <= operandA;
            exOpB <= operandB;
            exUseImm <= useImm;
            exImm <= imm;
            exPc <= decPc;
        end
    end

    always_comb begin
        valueA = forwardValue(exSrcA, exOpA);
        valueB = forwardValue(exSrcB, exOpB);
        aluB = exUseImm ? exImm : valueB;
        case (exAluOp)
            aluAdd: exResult = valueA + aluB;
            aluSub: exResult = valueA - aluB;
            aluAnd: exResult = valueA & aluB;
            aluUpperByte: exResult = {aluB[wordWidth/2-1:0], {(wordWidth/2){1'b0}}};
            default: exResult = aluB;  // mv
        endcase
    end

    assign exStoreData = valueA;  // st writes rX
    assign exAddr = valueB;  // ld and st address from rY
    assign branchTaken = exBranch && (valueA != '0);
    assign branchTarget = exPc + 1'b1 + exImm;

endmodule

`default_nettype wire

//--- verilog/resultWriteback.sv
//////////////////////////////////////////////////////////////////////
// Memory and writeback stages: data port, wait handling, result select
//////////////////////////////////////////////////////////////////////
`default_nettype none

module resultWriteback (
    input  wire                           Clock,
    input  wire                           Reset,
    input  wire                           Enable,
    input  wire                           DataWaitreq,
    input  wire [isaPkg::wordWidth-1:0]   DataIn,
    input  wire [isaPkg::wordWidth-1:0]   exResult,
    input  wire [isaPkg::wordWidth-1:0]   exStoreData,
    input  wire [isaPkg::wordWidth-1:0]   exAddr,
    input  wire                           exMemRead,
    input  wire                           exMemWrite,
    input  wire                           exWriteEnable,
    input  wire [isaPkg::regBits-1:0]     exDestReg,
    input  wire pipePkg::resultSrcT       exResultSrc,
    output logic [isaPkg::wordWidth-1:0]  DataAddr,
    output logic [isaPkg::wordWidth-1:0]  DataOut,
    output logic                          ReadData,
    output logic                          WriteData,
    output logic                          hold,
    output logic [isaPkg::wordWidth-1:0]  memResult,
    output logic                          memWriteEnable,
    output logic [isaPkg::regBits-1:0]    memDestReg,
    output logic                          wbEnable,
    output logic [isaPkg::regBits-1:0]    wbReg,
    output logic [isaPkg::wordWidth-1:0]  wbData
);
    import pipePkg::*;

    logic memRegWrite;  // memory stage instruction writes rX
    resultSrcT memSrc;

    // the whole pipeline waits on a pending access or while disabled
    assign hold = !Enable || (DataWaitreq && (ReadData || WriteData));

    // load data is not there yet, so a load is never forwarded from here
    assign memWriteEnable = memRegWrite && !ReadData;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            ReadData <= 1'b0;
            WriteData <= 1'b0;
            memRegWrite <= 1'b0;
            wbEnable <= 1'b0;
        end else if (!hold) begin
            ReadData <= exMemRead;
            WriteData <= exMemWrite;
            memRegWrite <= exWriteEnable;
            wbEnable <= memRegWrite;
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold) begin
            DataAddr <= exAddr;
            DataOut <= exStoreData;
            memResult <= exResult;
            memDestReg <= exDestReg;
            memSrc <= exResultSrc;
            wbReg <= memDestReg;
            wbData <= (memSrc == srcMemory) ? DataIn : memResult;  // DataIn valid at this edge
        end
    end

endmodule

`default_nettype wire

//--- verilog/pipelineCpu.sv
//////////////////////////////////////////////////////////////////////
// Five-stage 16-bit processor top level
//////////////////////////////////////////////////////////////////////
`default_nettype none

module pipelineCpu (
    input  wire                           Clock,
    input  wire                           Reset,
    input  wire                           Enable,
    input  wire [isaPkg::wordWidth-1:0]   InstrIn,
    input  wire [isaPkg::wordWidth-1:0]   DataIn,
    input  wire                           DataWaitreq,
    output logic [isaPkg::wordWidth-1:0]  InstrAddr,
    output logic [isaPkg::wordWidth-1:0]  DataAddr,
    output logic [isaPkg::wordWidth-1:0]  DataOut,
    output logic                          ReadData,
    output logic                          WriteData
);
    import isaPkg::*;
    import pipePkg::*;

    // stall, flush and hold
    logic hold;
    logic loadUseStall;
    logic branchTaken;
    logic [wordWidth-1:0] branchTarget;

    // fetch to decode
    logic [wordWidth-1:0] instrWord;
    logic [wordWidth-1:0] instrPc;
    logic fetchValid;

    // decode and register file
    logic [regBits-1:0] readRegA;
    logic [regBits-1:0] readRegB;
    logic [wordWidth-1:0] readDataA;
    logic [wordWidth-1:0] readDataB;
    aluOpT aluOp;
    resultSrcT resultSrc;
    logic memRead;
    logic memWrite;
    logic writeEnable;
    logic [regBits-1:0] destReg;
    logic [regBits-1:0] srcRegA;
    logic [regBits-1:0] srcRegB;
    logic [wordWidth-1:0] operandA;
    logic [wordWidth-1:0] operandB;
    logic useImm;
    logic [wordWidth-1:0] imm;
    logic isBranch;
    logic [wordWidth-1:0] decPc;

    // execute to memory
    logic [wordWidth-1:0] exResult;
    logic [wordWidth-1:0] exStoreData;
    logic [wordWidth-1:0] exAddr;
    logic exMemRead;
    logic exMemWrite;
    logic exWriteEnable;
    logic [regBits-1:0] exDestReg;
    resultSrcT exResultSrc;

    // forwarding and writeback
    logic [wordWidth-1:0] memResult;
    logic memWriteEnable;
    logic [regBits-1:0] memDestReg;
    logic wbEnable;
    logic [regBits-1:0] wbReg;
    logic [wordWidth-1:0] wbData;

    fetchUnit u_fetchUnit (.*);
    instrDecoder u_instrDecoder (.*);
    regFile u_regFile (.*);
    aluExecute u_aluExecute (.*);
    resultWriteback u_resultWriteback (.*);

endmodule

`default_nettype wire

//--- verif/cpuClockGen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock (period 40) and reset pulse of 5 cycles
//////////////////////////////////////////////////////////////////////
`default_nettype none

module cpuClockGen (
    output logic Clock,
    output logic Reset
);
    localparam int halfPeriod = 20;
    localparam int resetCycles = 5;

    initial begin
        Clock = 1'b0;
        Reset = 1'b1;  // held until the first case starts
    end

    always #halfPeriod Clock = ~Clock;

    // asserted and released on falling edges like every other DUT input
    task automatic pulseReset();
        @(negedge Clock);
        Reset = 1'b1;
        repeat (resetCycles) @(negedge Clock);
        Reset = 1'b0;
    endtask

endmodule

`default_nettype wire

//--- verif/cpuChecker.sv
//////////////////////////////////////////////////////////////////////
// Store checker: compares data port writes with the expected list
//////////////////////////////////////////////////////////////////////
`default_nettype none

module cpuChecker (
    input  wire                          Clock,
    input  wire                          Reset,
    input  wire [isaPkg::wordWidth-1:0]  InstrAddr,
    input  wire [isaPkg::wordWidth-1:0]  DataAddr,
    input  wire [isaPkg::wordWidth-1:0]  DataOut,
    input  wire                          ReadData,
    input  wire                          WriteData,
    input  wire                          DataWaitreq
);
    import isaPkg::*;

    logic [wordWidth-1:0] expAddr[$];
    logic [wordWidth-1:0] expData[$];
    int storeCount = 0;
    int errorCount = 0;

    task automatic expectStore(input logic [wordWidth-1:0] addr, input logic [wordWidth-1:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic endCase(input int caseIndex);
        if (expAddr.size() != 0) begin
            $display("Case %0d: %0d expected stores never happened", caseIndex, expAddr.size());
            errorCount++;
        end
        expAddr.delete();
        expData.delete();
    endtask

    // a store completes at the rising edge where DataWaitreq is low
    always @(posedge Clock) begin : storeCompare
        logic [wordWidth-1:0] addr;
        logic [wordWidth-1:0] data;
        if (!Reset && WriteData && !DataWaitreq) begin
            if (expAddr.size() == 0) begin
                $display("Unexpected store of 0x%h to address 0x%h", DataOut, DataAddr);
                errorCount++;
            end else begin
                addr = expAddr.pop_front();
                data = expData.pop_front();
                storeCount++;
                if (DataAddr !== addr) begin
                    $display("FAIL DataAddr expected 0x%h got 0x%h", addr, DataAddr);
                    errorCount++;
                end
                if (DataOut !== data) begin
                    $display("FAIL DataOut expected 0x%h got 0x%h", data, DataOut);
                    errorCount++;
                end
            end
        end
    end

    // state right after reset is released
    always @(negedge Reset) begin
        if (InstrAddr !== '0) begin
            $display("FAIL InstrAddr expected 0x%h got 0x%h", 16'h0000, InstrAddr);
            errorCount++;
        end
        if (ReadData !== 1'b0 || WriteData !== 1'b0) begin
            $display("A data strobe is active right after reset");
            errorCount++;
        end
    end

endmodule

`default_nettype wire

//--- verif/pipelineCpu_assert.sv
//////////////////////////////////////////////////////////////////////
// Data port protocol assertions, bound into the processor top level
//////////////////////////////////////////////////////////////////////
`default_nettype none

module pipelineCpu_assert (
    input wire                          Clock,
    input wire                          Reset,
    input wire                          ReadData,
    input wire                          WriteData,
    input wire                          DataWaitreq,
    input wire [isaPkg::wordWidth-1:0]  DataAddr,
    input wire [isaPkg::wordWidth-1:0]  DataOut
);
    strobesExclusive: assert property (@(posedge Clock) !(ReadData && WriteData))
        else $error("ReadData and WriteData high together");

    // a waiting access keeps the whole port frozen
    holdStable: assert property (@(posedge Clock) disable iff (Reset)
        (ReadData || WriteData) && DataWaitreq |=>
        $stable(DataAddr) && $stable(DataOut) && $stable(ReadData) && $stable(WriteData))
        else $error("data port changed while DataWaitreq was high");

    resetQuiet: assert property (@(posedge Clock) Reset |-> !ReadData && !WriteData)
        else $error("data strobe active during reset");

endmodule

bind pipelineCpu pipelineCpu_assert u_pipelineCpuAssert (.*);

`default_nettype wire

//--- verif/cpuTb.sv
//////////////////////////////////////////////////////////////////////
// Testbench top: processor, instruction ROM, data RAM and case loader
//////////////////////////////////////////////////////////////////////
`default_nettype none

module cpuTb;
    import isaPkg::*;

    localparam int romWords = 512;
    localparam int ramWords = 256;
    localparam int caseWords = 512;
    localparam int timeoutCycles = 2000;
    localparam logic [wordWidth-1:0] endAddr = 16'h00ff;  // store here ends a case
    localparam logic [wordWidth-1:0] nopWord = 16'he000;

    wire Clock;
    wire Reset;
    logic Enable;
    logic [wordWidth-1:0] InstrIn;
    logic [wordWidth-1:0] DataIn;
    logic DataWaitreq;
    wire [wordWidth-1:0] InstrAddr;
    wire [wordWidth-1:0] DataAddr;
    wire [wordWidth-1:0] DataOut;
    wire ReadData;
    wire WriteData;

    logic [wordWidth-1:0] rom [romWords];
    logic [wordWidth-1:0] ram [ramWords];
    logic [wordWidth-1:0] caseMem [caseWords];
    logic [8:0] romAddr;  // ROM address register giving one cycle of latency
    int waitProb;
    int timeoutCount;
    int seedValue;

    cpuClockGen u_clockGen (.Clock(Clock), .Reset(Reset));
    pipelineCpu u_pipelineCpu (.*);
    cpuChecker u_checker (.*);

    always @(posedge Clock) begin
        romAddr <= InstrAddr[8:0];
        if (WriteData && !DataWaitreq)
            ram[DataAddr[7:0]] <= DataOut;
    end

    always @(negedge Clock) begin
        InstrIn <= rom[romAddr];
        DataIn <= ReadData ? ram[DataAddr[7:0]] : 'x;  // RAM answers only a read
        DataWaitreq <= (waitProb > 0) && (int'($urandom % 100) < waitProb);
    end

    task automatic fillMemories();
        for (int i = 0; i < romWords; i++)
            rom[i] = nopWord;
        for (int a = 0; a < ramWords; a++)
            ram[a] = {a[7:0], ~a[7:0]};  // each word tells its own address
    endtask

    task automatic waitForEndMarker(input int caseIndex);
        int cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < timeoutCycles) begin
            @(posedge Clock);
            if (WriteData && !DataWaitreq && DataAddr == endAddr)
                done = 1'b1;
            cycles++;
        end
        if (!done) begin
            $display("Case %0d: no store to the end address within %0d cycles",
                caseIndex, timeoutCycles);
            timeoutCount++;
        end
    endtask

    initial begin
        int ptr;
        int caseIndex;
        int progLen;
        int storeTotal;
        Enable = 1'b1;
        InstrIn = '0;
        DataIn = '0;
        DataWaitreq = 1'b0;
        romAddr = '0;
        waitProb = 0;
        timeoutCount = 0;
        seedValue = $urandom(32'ha73c);
        for (int i = 0; i < caseWords; i++)
            caseMem[i] = '0;
        $readmemh("verif/cpuCases.txt", caseMem);
        ptr = 0;
        caseIndex = 0;
        while (caseMem[ptr] != 0 && timeoutCount == 0) begin
            progLen = caseMem[ptr];
            waitProb = caseMem[ptr+1];
            storeTotal = caseMem[ptr+2];
            ptr += 3;
            fillMemories();
            for (int i = 0; i < progLen; i++)
                rom[i] = caseMem[ptr+i];
            ptr += progLen;
            for (int i = 0; i < storeTotal; i++)
                u_checker.expectStore(caseMem[ptr+2*i], caseMem[ptr+2*i+1]);
            ptr += 2 * storeTotal;
            u_clockGen.pulseReset();
            waitForEndMarker(caseIndex);
            @(negedge Clock);
            u_checker.endCase(caseIndex);
            caseIndex++;
        end
        $display("Stores checked: %0d, errors: %0d, timeouts: %0d",
            u_checker.storeCount, u_checker.errorCount, timeoutCount);
        if (u_checker.errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pipelineCpu.f
common/isaPkg.sv
common/pipePkg.sv
verilog/fetchUnit.sv
decode/instrDecoder.sv
verilog/regFile.sv
execute/aluExecute.sv
verilog/resultWriteback.sv
verilog/pipelineCpu.sv
verif/cpuClockGen.sv
verif/cpuChecker.sv
verif/pipelineCpu_assert.sv
verif/cpuTb.sv

//--- verif/cpuCases.txt
// each case: program length, wait percent, store count, then the program words,
// then the expected stores as address and data pairs; a zero length ends the list
19 0 7
1C01 1212 5205 A206 34AB 16CD 4403 5C01 A406 74CD 5C01 A406 0A02 DBFF 18F0 C801
5C01 AA06 5C01 A806 6801 5C01 A806 1EFF A007
0001 0017 0002 ABCD 0003 AB00 0004 0100 0005 0010 0006 FFF9 00FF 0000
D 0 4
1220 8401 5401 1C01 A406 8606 A601 8804 D8F0 5C01 A806 1EFF A007
0001 20E0 0020 20E0 0002 00F0 00FF 0000
A 0 7
1205 1C10 A206 5C01 7201 23FC 5433 A406 1EFF A007
0010 0005 0011 0004 0012 0003 0013 0002 0014 0001 0015 0033 00FF 0000
D 32 4
1220 8401 5401 1C01 A406 8606 A601 8804 D8F0 5C01 A806 1EFF A007
0001 20E0 0020 20E0 0002 00F0 00FF 0000
9 0 4
165A 1C30 E7FF A606 E7FF A606 AC03 1EFF A007
0030 005A 0030 005A 005A 0030 00FF 0000
0 0 0
